//--- hdl/fetch_pkg.sv
package fetch_pkg;

  // Address split is tag | index | word select | byte offset
  localparam int WORD_W     = 32;
  localparam int TAG_W      = 17;
  localparam int INDEX_W    = 10;
  localparam int WORD_SEL_W = 3;
  localparam int OFFSET_W   = WORD_SEL_W + 2;      // Byte offset within a line

  localparam int LINE_WORDS = 8;
  localparam int LINES      = 1024;
  localparam int LINE_W     = LINE_WORDS * WORD_W;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LINE_W-1:0] line_t;                // Word 0 in the low bits

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_WRITE
  } fetch_state_e;

  function automatic logic [TAG_W-1:0] addr_tag(input word_t a);
    return a[WORD_W-1 -: TAG_W];
  endfunction

  function automatic logic [INDEX_W-1:0] addr_index(input word_t a);
    return a[OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [WORD_SEL_W-1:0] addr_word_sel(input word_t a);
    return a[2 +: WORD_SEL_W];
  endfunction

endpackage

//--- hdl/icache_array.sv
`timescale 1ns/1ps

module icache_array import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  RESET,
  input  logic  flush_go,
  input  logic  rd_en,
  input  word_t rd_addr,
  output logic  hit,
  output word_t rd_word,
  input  logic  wr_en,
  input  word_t wr_addr,
  input  line_t wr_line
);

  logic [LINES-1:0] valid_q;
  logic [TAG_W-1:0] tag_mem [LINES];
  line_t            data_mem [LINES];

  logic [INDEX_W-1:0] rd_index;
  logic [INDEX_W-1:0] wr_index;
  logic [TAG_W-1:0]   rd_tag;
  logic [TAG_W-1:0]   wr_tag;
  logic               bypass;

  logic                  rd_valid_q;
  logic [TAG_W-1:0]      stored_tag_q;
  logic [TAG_W-1:0]      req_tag_q;
  line_t                 rd_line_q;
  logic [WORD_SEL_W-1:0] word_sel_q;

  assign rd_index = addr_index(rd_addr);
  assign wr_index = addr_index(wr_addr);
  assign rd_tag   = addr_tag(rd_addr);
  assign wr_tag   = addr_tag(wr_addr);

  // Read of the line being written sees the new contents
  assign bypass = wr_en && (wr_index == rd_index);

  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      valid_q <= '0;
    end else if (flush_go) begin
      valid_q <= '0;                                // Whole cache invalid in one cycle
    end else if (wr_en) begin
      valid_q[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      tag_mem[wr_index]  <= wr_tag;
      data_mem[wr_index] <= wr_line;
    end
  end

  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      rd_valid_q <= 1'b0;
    end else if (flush_go) begin
      rd_valid_q <= 1'b0;
    end else if (rd_en) begin
      rd_valid_q <= bypass || valid_q[rd_index];
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_en) begin
      req_tag_q  <= rd_tag;
      word_sel_q <= addr_word_sel(rd_addr);
      if (bypass) begin
        stored_tag_q <= wr_tag;
        rd_line_q    <= wr_line;
      end else begin
        stored_tag_q <= tag_mem[rd_index];
        rd_line_q    <= data_mem[rd_index];
      end
    end
  end

  assign hit     = rd_valid_q && (stored_tag_q == req_tag_q);
  assign rd_word = rd_line_q[word_sel_q * WORD_W +: WORD_W];   // Word select by addr[4:2]

  // Controller keeps line writes and flushes in different states
  a_no_write_during_flush : assert property (
    @(posedge CLK) disable iff (!RESET) !(wr_en && flush_go)
  ) else $error("icache_array: wr_en and flush_go high together");

endmodule

//--- hdl/line_refill.sv
`timescale 1ns/1ps

module line_refill import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  RESET,
  input  logic  start,
  input  word_t line_addr,
  output logic  done,
  output line_t line,
  output logic  wb_cyc,
  output logic  wb_stb,
  output word_t wb_adr,
  input  word_t wb_dat_i,
  input  logic  wb_ack
);

  logic                   busy_q;
  logic                   stb_q;
  logic                   done_q;
  logic [WORD_SEL_W-1:0]  cnt_q;
  logic [WORD_W-1:OFFSET_W] base_q;
  line_t                  line_q;
  logic                   beat;
  logic                   last_word;

  assign beat      = stb_q && wb_ack;
  assign last_word = (cnt_q == WORD_SEL_W'(LINE_WORDS - 1));

  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      busy_q <= 1'b0;
      stb_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        busy_q <= 1'b1;
        stb_q  <= 1'b1;
        cnt_q  <= '0;
      end else if (beat) begin
        stb_q <= 1'b0;                              // One idle cycle between words
        if (last_word) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end else if (busy_q && !stb_q) begin
        stb_q <= 1'b1;                              // Next single read
      end
    end
  end

  // Line aligned base address
  always_ff @(posedge CLK) begin
    if (start) begin
      base_q <= line_addr[WORD_W-1:OFFSET_W];
    end
  end

  // Words arrive in address order so word 0 ends in the low slot
  always_ff @(posedge CLK) begin
    if (beat) begin
      line_q <= {wb_dat_i, line_q[LINE_W-1:WORD_W]};
    end
  end

  assign wb_cyc = busy_q;
  assign wb_stb = stb_q;
  assign wb_adr = {base_q, cnt_q, 2'b00};
  assign done   = done_q;
  assign line   = line_q;

  a_stb_inside_cyc : assert property (
    @(posedge CLK) disable iff (!RESET) $rose(wb_stb) |-> wb_cyc
  ) else $error("line_refill: wb_stb rose outside wb_cyc");

  a_no_start_when_busy : assert property (
    @(posedge CLK) disable iff (!RESET) start |-> !busy_q
  ) else $error("line_refill: start during a refill");

endmodule

//--- hdl/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  RESET,
  input  logic  req,
  input  word_t addr,
  input  logic  flush,
  output logic  ack,
  output word_t instr,
  output logic  flush_go,
  output logic  rd_en,
  output word_t rd_addr,
  input  logic  hit,
  input  word_t rd_word,
  output logic  wr_en,
  output word_t wr_addr,
  output line_t wr_line,
  output logic  start,
  output word_t line_addr,
  input  logic  done,
  input  line_t line
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  word_t        addr_q;
  word_t        instr_q;
  logic         ack_q;
  logic         start_q;
  logic         take_req;
  logic         lookup_hit;
  logic         lookup_miss;

  // Ignore req during the ack cycle since the core still holds it
  assign take_req    = (state_q == ST_IDLE) && req && !ack_q && !flush;
  assign flush_go    = (state_q == ST_IDLE) && flush;
  assign lookup_hit  = (state_q == ST_LOOKUP) && hit;
  assign lookup_miss = (state_q == ST_LOOKUP) && !hit;

  assign rd_en   = take_req || (state_q == ST_WRITE);   // Re-lookup launched with the write
  assign rd_addr = (state_q == ST_IDLE) ? addr : addr_q;

  assign wr_en   = (state_q == ST_WRITE);
  assign wr_addr = addr_q;
  assign wr_line = line;

  assign start     = start_q;
  assign line_addr = addr_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:   if (take_req) state_d = ST_LOOKUP;
      ST_LOOKUP: state_d = hit ? ST_IDLE : ST_REFILL;
      ST_REFILL: if (done) state_d = ST_WRITE;
      ST_WRITE:  state_d = ST_LOOKUP;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      state_q <= ST_IDLE;
      ack_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= lookup_hit;
      start_q <= lookup_miss;
    end
  end

  always_ff @(posedge CLK) begin
    if (take_req) begin
      addr_q <= addr;
    end
    if (lookup_hit) begin
      instr_q <= rd_word;
    end
  end

  assign ack   = ack_q;
  assign instr = instr_q;

  // Freshly written line must be found by the lookup that follows it
  a_hit_after_write : assert property (
    @(posedge CLK) disable iff (!RESET) (state_q == ST_WRITE) |=> hit
  ) else $error("fetch_ctrl: lookup after line write missed");

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  RESET,
  input  logic  req,
  input  word_t addr,
  input  logic  flush,
  output logic  ack,
  output word_t instr,
  output logic  wb_cyc,
  output logic  wb_stb,
  output word_t wb_adr,
  input  word_t wb_dat_i,
  input  logic  wb_ack
);

  logic  flush_go;
  logic  rd_en;
  word_t rd_addr;
  logic  hit;
  word_t rd_word;
  logic  wr_en;
  word_t wr_addr;
  line_t wr_line;
  logic  start;
  word_t line_addr;
  logic  done;
  line_t refill_line;

  fetch_ctrl i_fetch_ctrl (
    .CLK       (CLK),
    .RESET     (RESET),
    .req       (req),
    .addr      (addr),
    .flush     (flush),
    .ack       (ack),
    .instr     (instr),
    .flush_go  (flush_go),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .hit       (hit),
    .rd_word   (rd_word),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_line   (wr_line),
    .start     (start),
    .line_addr (line_addr),
    .done      (done),
    .line      (refill_line)
  );

  icache_array i_icache_array (
    .CLK      (CLK),
    .RESET    (RESET),
    .flush_go (flush_go),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .hit      (hit),
    .rd_word  (rd_word),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_line  (wr_line)
  );

  line_refill i_line_refill (
    .CLK       (CLK),
    .RESET     (RESET),
    .start     (start),
    .line_addr (line_addr),
    .done      (done),
    .line      (refill_line),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack)
  );

endmodule

//--- testbench/tb_wb_memory.sv
`timescale 1ns/1ps

module tb_wb_memory import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  RESET,
  input  logic  wb_cyc,
  input  logic  wb_stb,
  input  word_t wb_adr,
  output word_t wb_dat,
  output logic  wb_ack
);

  localparam int MAX_WAIT = 3;

  logic pending;
  int   wait_left;

  // Memory contents follow from the word address alone
  function automatic word_t mem_word(input word_t a);
    word_t wa;
    wa = {2'b00, a[31:2]};
    return {wa[24:0], wa[31:25]} ^ 32'h1badf00d;
  endfunction

  // Slave outputs change on the falling edge only
  initial begin
    wb_ack    = 1'b0;
    wb_dat    = '0;
    pending   = 1'b0;
    wait_left = 0;
    forever begin
      @(negedge CLK);
      if (!RESET) begin
        wb_ack    = 1'b0;
        pending   = 1'b0;
        wait_left = 0;
      end else if (wb_ack) begin
        wb_ack = 1'b0;                              // Ack lasts one cycle
      end else if (wb_cyc && wb_stb) begin
        if (!pending) begin
          pending   = 1'b1;
          wait_left = $urandom_range(MAX_WAIT, 0);  // Draw wait states for a new request
        end
        if (wait_left == 0) begin
          wb_ack  = 1'b1;
          wb_dat  = mem_word(wb_adr);
          pending = 1'b0;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

endmodule

//--- testbench/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

  localparam int          CLK_HALF     = 50;
  localparam int          RESET_CYCLES = 8;
  localparam logic [31:0] SEED         = 32'hda4a1823;
  localparam int          N_DIRECTED   = 14;
  localparam int          N_RANDOM     = 300;
  localparam int          FETCH_LIMIT  = 64;
  localparam int          HIT_LATENCY  = 2;
  localparam int          WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * FETCH_LIMIT + 2000;

  logic  CLK;
  logic  RESET;
  logic  req;
  word_t addr;
  logic  flush;
  logic  ack;
  word_t instr;
  logic  wb_cyc;
  logic  wb_stb;
  word_t wb_adr;
  word_t wb_dat_i;
  logic  wb_ack;

  // Reference tag model
  logic [LINES-1:0] valid_m;
  logic [TAG_W-1:0] tag_m [LINES];

  word_t fetch_addr;
  int    bus_beats;
  int    ack_count;
  int    refills;
  int    fetches;
  int    word_errors;
  int    count_errors;
  int    other_errors;

  fetch_top i_fetch_top (
    .CLK      (CLK),
    .RESET    (RESET),
    .req      (req),
    .addr     (addr),
    .flush    (flush),
    .ack      (ack),
    .instr    (instr),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack)
  );

  tb_wb_memory i_wb_memory (
    .CLK    (CLK),
    .RESET  (RESET),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_adr (wb_adr),
    .wb_dat (wb_dat_i),
    .wb_ack (wb_ack)
  );

  initial begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  // Expected word is the word address rotated left by 7 and xored with a constant
  function automatic word_t ref_word(input word_t a);
    word_t wa;
    wa = {2'b00, a[31:2]};
    return {wa[24:0], wa[31:25]} ^ 32'h1badf00d;
  endfunction

  function automatic word_t rand_addr();
    word_t a;
    a = '0;
    a[16:15] = 2'($urandom_range(3, 0));            // Four tags compete for each index
    a[9:5]   = 5'($urandom_range(31, 0));
    a[4:2]   = 3'($urandom_range(7, 0));
    return a;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      word_errors++;
      $display("FAIL %s got 0x%08h exp 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      count_errors++;
      $display("FAIL %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  task automatic update_tag_model(input word_t a, output bit miss);
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    idx  = a[14:5];
    tag  = a[31:15];
    miss = !valid_m[idx] || (tag_m[idx] != tag);
    valid_m[idx] = 1'b1;
    tag_m[idx]   = tag;
  endtask

  task automatic do_fetch(input word_t a);
    bit miss;
    int beats_before;
    int cycles;
    update_tag_model(a, miss);
    if (miss) begin
      refills++;
    end
    @(negedge CLK);
    beats_before = bus_beats;
    fetch_addr   = a;
    req          = 1'b1;
    addr         = a;
    cycles       = 0;
    do begin
      @(negedge CLK);
      cycles++;
    end while (!ack && cycles < FETCH_LIMIT);
    req = 1'b0;
    if (!ack) begin
      other_errors++;
      $display("No ack for fetch of 0x%08h within %0d cycles", a, FETCH_LIMIT);
    end else begin
      check_word("instr", instr, ref_word(a));
      check_count("wb_transfers", bus_beats - beats_before, miss ? LINE_WORDS : 0);
      if (!miss) begin
        check_count("hit_latency", cycles, HIT_LATENCY);
      end
    end
    fetches++;
  endtask

  task automatic do_flush();
    @(negedge CLK);
    flush = 1'b1;
    @(negedge CLK);
    flush   = 1'b0;
    valid_m = '0;
  endtask

  // Bus and ack monitor samples on the rising edge like the DUT
  always @(posedge CLK) begin
    if (RESET) begin
      if (ack) begin
        ack_count++;
      end
      if (wb_cyc && wb_stb && wb_ack) begin
        bus_beats++;
        if (wb_adr[31:5] != fetch_addr[31:5]) begin
          other_errors++;
          $display("Bus read at 0x%08h outside the line of fetch 0x%08h", wb_adr, fetch_addr);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    RESET        = 1'b0;
    req          = 1'b0;
    addr         = '0;
    flush        = 1'b0;
    valid_m      = '0;
    fetch_addr   = '0;
    bus_beats    = 0;
    ack_count    = 0;
    refills      = 0;
    fetches      = 0;
    word_errors  = 0;
    count_errors = 0;
    other_errors = 0;
    repeat (RESET_CYCLES) @(negedge CLK);
    RESET = 1'b1;

    do_fetch(32'h0000_1044);                        // Cold miss
    do_fetch(32'h0000_1044);
    do_fetch(32'h0000_1040);
    do_fetch(32'h0000_105c);
    for (int i = 0; i < 4; i++) begin               // Tags with the same index evict each other
      do_fetch(32'h0000_2088);
      do_fetch(32'h0003_2088);
    end
    do_fetch(32'h0000_1048);
    do_flush();
    do_fetch(32'h0000_1048);                        // Refill after flush

    for (int i = 0; i < N_RANDOM; i++) begin
      do_fetch(rand_addr());
    end

    @(negedge CLK);
    check_count("bus_transfers", bus_beats, refills * LINE_WORDS);
    check_count("acks", ack_count, fetches);
    $display("Errors: data %0d, count %0d, other %0d (fetches %0d, refills %0d)",
             word_errors, count_errors, other_errors, fetches, refills);
    if (word_errors + count_errors + other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/fetch_pkg.sv
hdl/icache_array.sv
hdl/line_refill.sv
hdl/fetch_ctrl.sv
hdl/fetch_top.sv
testbench/tb_wb_memory.sv
testbench/tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_icache

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/icache_array.sv
      - hdl/line_refill.sv
      - hdl/fetch_ctrl.sv
      - hdl/fetch_top.sv
  - target: test
    files:
      - testbench/tb_wb_memory.sv
      - testbench/tb_fetch_top.sv
